// ==== files.f ====
rtl/capreg_pkg.sv
rtl/rf_cmd_if.sv
rtl/rf_rd_if.sv
rtl/rf_cmd_intake.sv
rtl/cap_regfile.sv
rtl/rf_read_port.sv
rtl/cap_rf_top.sv
test/cap_rf_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the capability register file testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module cap_rf_tb -o Vcap_rf_tb

out=$(./obj_dir/Vcap_rf_tb)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

// ==== test/cap_rf_tb.sv ====
// ****************************************
// drives cap_rf_top through both four-phase channels
// expects every command to be acked three cycles after req is sampled
// ****************************************
`default_nettype none

module cap_rf_tb import capreg_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_RAND     = 24;
  localparam int STALL_CYCLES = 20;
  localparam int RES_W        = DATA_W + PERM_W + 1;
  // reset reads, random writes and reads, register 0, stall and clrtag sequences
  localparam int TOTAL_OPS    = NUM_REGS + 2 * NUM_RAND + 2 + 4 + 3;

  logic              clk_i;
  logic              par_rst_ni;
  logic              cmd_req_i;
  logic              cmd_ack_o;
  rf_op_e            cmd_op_i;
  logic [ADDR_W-1:0] cmd_addr_i;
  logic [DATA_W-1:0] cmd_data_i;
  logic              cmd_cap_valid_i;
  logic [PERM_W-1:0] cmd_cap_perms_i;
  logic              cmd_clrtag_i;
  logic              rd_req_i;
  logic              rd_ack_o;
  logic [ADDR_W-1:0] rd_addr_i;
  logic [DATA_W-1:0] rd_data_o;
  logic              rd_cap_valid_o;
  logic [PERM_W-1:0] rd_cap_perms_o;

  // shadow model of the register file
  logic [DATA_W-1:0] m_data  [NUM_REGS];
  logic              m_tag   [NUM_REGS];
  logic [PERM_W-1:0] m_perms [NUM_REGS];
  logic              m_ready [NUM_REGS];

  // completed reads waiting for the compare process
  string             name_q [$];
  logic [RES_W-1:0]  exp_q  [$];
  logic [RES_W-1:0]  got_q  [$];

  int     errors  = 0;
  int     checked = 0;
  integer seed    = 32'hb5f7;
  logic [31:0] r;
  logic [31:0] d;

  cap_rf_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // result layout is {data, tag, perms}
  function automatic logic [RES_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
    if (addr == '0) return '0;
    return {m_data[addr], m_tag[addr], m_perms[addr]};
  endfunction

  function automatic void model_apply(input rf_op_e op, input logic [ADDR_W-1:0] addr,
                                      input logic [DATA_W-1:0] data, input logic tag,
                                      input logic [PERM_W-1:0] perms, input logic clrtag);
    if (addr == '0) return;
    case (op)
      OP_WRITE: begin
        m_data[addr]  = data;
        m_tag[addr]   = tag;
        m_perms[addr] = perms;
      end
      OP_RESERVE: m_ready[addr] = 1'b0;
      OP_REVOKE: begin
        m_ready[addr] = 1'b1;
        if (clrtag) m_tag[addr] = 1'b0;
      end
      default: ;
    endcase
  endfunction

  task automatic send_cmd(input rf_op_e op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, input logic tag,
                          input logic [PERM_W-1:0] perms, input logic clrtag);
    int cycles;
    @(posedge clk_i);
    cmd_req_i       <= 1'b1;
    cmd_op_i        <= op;
    cmd_addr_i      <= addr;
    cmd_data_i      <= data;
    cmd_cap_valid_i <= tag;
    cmd_cap_perms_i <= perms;
    cmd_clrtag_i    <= clrtag;
    cycles = 0;
    // the first edge after driving req is the one that samples it
    do begin
      @(posedge clk_i);
      cycles++;
      @(negedge clk_i);
    end while (!cmd_ack_o);
    assert (cycles == 3) else begin
      errors++;
      $display("Error: cmd_latency expected %0d actual %0d", 3, cycles);
    end
    model_apply(op, addr, data, tag, perms, clrtag);
    @(posedge clk_i);
    cmd_req_i <= 1'b0;
    do @(negedge clk_i); while (cmd_ack_o);
  endtask

  task automatic do_read(input logic [ADDR_W-1:0] addr, input string name);
    logic [RES_W-1:0] expected;
    expected = expected_read(addr);
    @(posedge clk_i);
    rd_req_i  <= 1'b1;
    rd_addr_i <= addr;
    do @(negedge clk_i); while (!rd_ack_o);
    got_q.push_back({rd_data_o, rd_cap_valid_o, rd_cap_perms_o});
    exp_q.push_back(expected);
    name_q.push_back(name);
    @(posedge clk_i);
    rd_req_i <= 1'b0;
    do @(negedge clk_i); while (rd_ack_o);
  endtask

  initial begin : compare_reads
    string            nm;
    logic [RES_W-1:0] e;
    logic [RES_W-1:0] g;
    forever begin
      @(negedge clk_i);
      while (got_q.size() != 0) begin
        nm = name_q.pop_front();
        e  = exp_q.pop_front();
        g  = got_q.pop_front();
        checked++;
        assert (g == e) else begin
          errors++;
          $display("Error: %s expected data=%h tag=%b perms=%h actual data=%h tag=%b perms=%h",
                   nm, e[RES_W-1:PERM_W+1], e[PERM_W], e[PERM_W-1:0],
                   g[RES_W-1:PERM_W+1], g[PERM_W], g[PERM_W-1:0]);
        end
      end
    end
  end

  initial begin
    cmd_req_i       = 1'b0;
    cmd_op_i        = OP_WRITE;
    cmd_addr_i      = '0;
    cmd_data_i      = '0;
    cmd_cap_valid_i = 1'b0;
    cmd_cap_perms_i = '0;
    cmd_clrtag_i    = 1'b0;
    rd_req_i        = 1'b0;
    rd_addr_i       = '0;
    par_rst_ni      = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      m_data[i]  = '0;
      m_tag[i]   = 1'b0;
      m_perms[i] = '0;
      m_ready[i] = 1'b1;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    par_rst_ni <= 1'b1;

    for (int a = 0; a < NUM_REGS; a++) do_read(ADDR_W'(a), "reset_read");

    // register 0 must ignore this write
    send_cmd(OP_WRITE, 4'd0, 32'hdead_beef, 1'b1, 8'hff, 1'b0);
    for (int i = 0; i < NUM_RAND; i++) begin
      r = $random(seed);
      d = $random(seed);
      send_cmd(OP_WRITE, r[3:0], d, r[4], r[15:8], 1'b0);
    end
    for (int i = 0; i < NUM_RAND; i++) begin
      r = $random(seed);
      do_read(r[3:0], "rand_read");
    end
    do_read(4'd0, "reg0_read");

    // reserved register stalls the read until it is revoked
    send_cmd(OP_WRITE, 4'd5, 32'h5a5a_1234, 1'b1, 8'h3c, 1'b0);
    send_cmd(OP_RESERVE, 4'd5, '0, 1'b0, '0, 1'b0);
    fork
      do_read(4'd5, "reserve_read");
      begin
        repeat (STALL_CYCLES) begin
          @(negedge clk_i);
          // no read ack while the model still has the register reserved
          assert (!rd_ack_o || m_ready[5]) else begin
            errors++;
            $display("Error: reserve_stall expected rd_ack_o %b actual %b",
                     m_ready[5], rd_ack_o);
          end
        end
        send_cmd(OP_REVOKE, 4'd5, '0, 1'b0, '0, 1'b0);
      end
    join

    send_cmd(OP_WRITE, 4'd9, 32'hcafe_f00d, 1'b1, 8'ha7, 1'b0);
    send_cmd(OP_REVOKE, 4'd9, '0, 1'b0, '0, 1'b1);
    do_read(4'd9, "revoke_clrtag");

    while (got_q.size() != 0) @(negedge clk_i);
    $display("errors: %0d, reads checked: %0d", errors, checked);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (TOTAL_OPS * 40 + RESET_CYCLES) @(posedge clk_i);
    $display("timeout: the DUT did not finish a handshake in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/cap_rf_top.sv ====
// ****************************************
// capability register file with separate command and read channels
// both channels use a four-phase req/ack handshake
// ****************************************
`default_nettype none

module cap_rf_top import capreg_pkg::*; (
  input  logic              clk_i,
  input  logic              par_rst_ni,

  // command channel
  input  logic              cmd_req_i,
  output logic              cmd_ack_o,
  input  rf_op_e            cmd_op_i,
  input  logic [ADDR_W-1:0] cmd_addr_i,
  input  logic [DATA_W-1:0] cmd_data_i,
  input  logic              cmd_cap_valid_i,
  input  logic [PERM_W-1:0] cmd_cap_perms_i,
  input  logic              cmd_clrtag_i,

  // read channel
  input  logic              rd_req_i,
  output logic              rd_ack_o,
  input  logic [ADDR_W-1:0] rd_addr_i,
  output logic [DATA_W-1:0] rd_data_o,
  output logic              rd_cap_valid_o,
  output logic [PERM_W-1:0] rd_cap_perms_o
);

  rf_cmd_if cmd_if ();
  rf_rd_if  rd_if ();

  rf_cmd_intake intake_i (
    .clk_i           (clk_i),
    .par_rst_ni      (par_rst_ni),
    .cmd_req_i       (cmd_req_i),
    .cmd_ack_o       (cmd_ack_o),
    .cmd_op_i        (cmd_op_i),
    .cmd_addr_i      (cmd_addr_i),
    .cmd_data_i      (cmd_data_i),
    .cmd_cap_valid_i (cmd_cap_valid_i),
    .cmd_cap_perms_i (cmd_cap_perms_i),
    .cmd_clrtag_i    (cmd_clrtag_i),
    .cmd             (cmd_if.intake)
  );

  cap_regfile regfile_i (
    .clk_i      (clk_i),
    .par_rst_ni (par_rst_ni),
    .cmd        (cmd_if.regfile),
    .rd         (rd_if.regfile)
  );

  rf_read_port read_port_i (
    .clk_i          (clk_i),
    .par_rst_ni     (par_rst_ni),
    .rd_req_i       (rd_req_i),
    .rd_ack_o       (rd_ack_o),
    .rd_addr_i      (rd_addr_i),
    .rd_data_o      (rd_data_o),
    .rd_cap_valid_o (rd_cap_valid_o),
    .rd_cap_perms_o (rd_cap_perms_o),
    .rd             (rd_if.port)
  );

endmodule

`default_nettype wire

// ==== rtl/rf_read_port.sv ====
// ****************************************
// bridges the external read handshake onto rf_rd_if
// outputs only hold a valid value while rd_ack_o is high
// ****************************************
`default_nettype none

module rf_read_port import capreg_pkg::*; (
  input  logic              clk_i,
  input  logic              par_rst_ni,
  input  logic              rd_req_i,
  output logic              rd_ack_o,
  input  logic [ADDR_W-1:0] rd_addr_i,
  output logic [DATA_W-1:0] rd_data_o,
  output logic              rd_cap_valid_o,
  output logic [PERM_W-1:0] rd_cap_perms_o,
  rf_rd_if.port             rd
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_DONE
  } state_e;

  state_e state_q;

  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] data_q;
  cap_t              cap_q;

  always_ff @(posedge clk_i or negedge par_rst_ni) begin
    if (!par_rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      unique case (state_q)
        ST_IDLE: if (rd_req_i) state_q <= ST_WAIT;
        // may sit here for a while on a reserved register
        ST_WAIT: if (rd.ack) state_q <= ST_DONE;
        ST_DONE: if (!rd_req_i && !rd.ack) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && rd_req_i) begin
      addr_q <= rd_addr_i;
    end
    if (state_q == ST_WAIT && rd.ack) begin
      data_q <= rd.data;
      cap_q  <= rd.cap;
    end
  end

  assign rd.req         = (state_q == ST_WAIT);
  assign rd.addr        = addr_q;
  assign rd_ack_o       = (state_q == ST_DONE);
  assign rd_data_o      = data_q;
  assign rd_cap_valid_o = cap_q.valid;
  assign rd_cap_perms_o = cap_q.perms;

  // reset must leave no stale response on the outputs
  a_no_ack_after_rst: assert property (@(posedge clk_i)
    $rose(par_rst_ni) |-> !rd_ack_o);

endmodule

`default_nettype wire

// ==== rtl/cap_regfile.sv ====
// ****************************************
// register 0 has no storage and always reads as zero, null cap
// a read of a reserved register stalls until it is revoked
// ****************************************
`default_nettype none

module cap_regfile import capreg_pkg::*; (
  input  logic      clk_i,
  input  logic      par_rst_ni,
  rf_cmd_if.regfile cmd,
  rf_rd_if.regfile  rd
);

  // flat views of the array, entry 0 tied off
  logic [DATA_W-1:0]   data_all [NUM_REGS];
  cap_t                cap_all  [NUM_REGS];
  logic [NUM_REGS-1:0] ready_all;

  logic cmd_ack_q;
  logic rd_ack_q;
  logic cmd_fire;
  logic rd_ready;
  logic rd_fire;

  logic [DATA_W-1:0] rd_data_q;
  cap_t              rd_cap_q;

  assign cmd_fire = cmd.req && !cmd_ack_q;

  assign data_all[0]  = '0;
  assign cap_all[0]   = NULL_CAP;
  assign ready_all[0] = 1'b1;

  for (genvar i = 1; i < NUM_REGS; i++) begin : g_regs
    logic [DATA_W-1:0] data_r;
    cap_t              cap_r;
    logic              ready_r;
    logic              hit;

    assign hit = cmd_fire && (cmd.addr == ADDR_W'(i));

    always_ff @(posedge clk_i or negedge par_rst_ni) begin
      if (!par_rst_ni) begin
        data_r  <= '0;
        cap_r   <= NULL_CAP;
        ready_r <= 1'b1;
      end else if (hit) begin
        case (cmd.op)
          OP_WRITE: begin
            data_r <= cmd.data;
            cap_r  <= cmd.cap;
          end
          // a capability load is in flight for this register
          OP_RESERVE: ready_r <= 1'b0;
          OP_REVOKE: begin
            ready_r <= 1'b1;
            if (cmd.clrtag) cap_r.valid <= 1'b0;
          end
          default: ;
        endcase
      end
    end

    assign data_all[i]  = data_r;
    assign cap_all[i]   = cap_r;
    assign ready_all[i] = ready_r;
  end

  // reads wait here until the addressed register is ready
  assign rd_ready = ready_all[rd.addr];
  assign rd_fire  = rd.req && !rd_ack_q && rd_ready;

  always_ff @(posedge clk_i or negedge par_rst_ni) begin
    if (!par_rst_ni) begin
      cmd_ack_q <= 1'b0;
      rd_ack_q  <= 1'b0;
    end else begin
      if (cmd_fire) cmd_ack_q <= 1'b1;
      else if (cmd_ack_q && !cmd.req) cmd_ack_q <= 1'b0;

      if (rd_fire) rd_ack_q <= 1'b1;
      else if (rd_ack_q && !rd.req) rd_ack_q <= 1'b0;
    end
  end

  // sampled before any command on the same edge lands
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      rd_data_q <= data_all[rd.addr];
      rd_cap_q  <= cap_all[rd.addr];
    end
  end

  assign cmd.ack = cmd_ack_q;
  assign rd.ack  = rd_ack_q;
  assign rd.data = rd_data_q;
  assign rd.cap  = rd_cap_q;

  a_cmd_ack_req: assert property (@(posedge clk_i) disable iff (!par_rst_ni)
    $rose(cmd.ack) |-> $past(cmd.req));

  a_rd_ack_req: assert property (@(posedge clk_i) disable iff (!par_rst_ni)
    $rose(rd.ack) |-> $past(rd.req));

  // no response may leak out of a reserved register
  a_rd_ack_ready: assert property (@(posedge clk_i) disable iff (!par_rst_ni)
    $rose(rd.ack) |-> $past(rd_ready));

endmodule

`default_nettype wire

// ==== rtl/rf_cmd_intake.sv ====
// ****************************************
// bridges the external command handshake onto rf_cmd_if
// the source must drop cmd_req_i before starting a new command
// ****************************************
`default_nettype none

module rf_cmd_intake import capreg_pkg::*; (
  input  logic              clk_i,
  input  logic              par_rst_ni,
  input  logic              cmd_req_i,
  output logic              cmd_ack_o,
  input  rf_op_e            cmd_op_i,
  input  logic [ADDR_W-1:0] cmd_addr_i,
  input  logic [DATA_W-1:0] cmd_data_i,
  input  logic              cmd_cap_valid_i,
  input  logic [PERM_W-1:0] cmd_cap_perms_i,
  input  logic              cmd_clrtag_i,
  rf_cmd_if.intake          cmd
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FWD,
    ST_DONE
  } state_e;

  state_e state_q;

  // held copy of the command while it is forwarded
  rf_op_e            op_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] data_q;
  cap_t              cap_q;
  logic              clrtag_q;

  always_ff @(posedge clk_i or negedge par_rst_ni) begin
    if (!par_rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      unique case (state_q)
        ST_IDLE: if (cmd_req_i) state_q <= ST_FWD;
        ST_FWD:  if (cmd.ack) state_q <= ST_DONE;
        // wait for both sides to return to zero
        ST_DONE: if (!cmd_req_i && !cmd.ack) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && cmd_req_i) begin
      op_q     <= cmd_op_i;
      addr_q   <= cmd_addr_i;
      data_q   <= cmd_data_i;
      cap_q    <= '{valid: cmd_cap_valid_i, perms: cmd_cap_perms_i};
      clrtag_q <= cmd_clrtag_i;
    end
  end

  assign cmd.req    = (state_q == ST_FWD);
  assign cmd.op     = op_q;
  assign cmd.addr   = addr_q;
  assign cmd.data   = data_q;
  assign cmd.cap    = cap_q;
  assign cmd.clrtag = clrtag_q;
  assign cmd_ack_o  = (state_q == ST_DONE);

  // a forwarded command is held until the register file takes it
  a_req_held: assert property (@(posedge clk_i) disable iff (!par_rst_ni)
    (cmd.req && !cmd.ack) |=>
      (cmd.req && $stable({cmd.op, cmd.addr, cmd.data, cmd.cap, cmd.clrtag})));

endmodule

`default_nettype wire

// ==== rtl/rf_rd_if.sv ====
// ****************************************
// internal read channel, four-phase req/ack
// data and cap are only valid while ack is high
// ****************************************
`default_nettype none

interface rf_rd_if;
  import capreg_pkg::*;

  logic              req;
  logic              ack;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data;
  cap_t              cap;

  // requesting side
  modport port (
    output req, addr,
    input  ack, data, cap
  );

  // responding side
  modport regfile (
    input  req, addr,
    output ack, data, cap
  );

endinterface

`default_nettype wire

// ==== rtl/rf_cmd_if.sv ====
// ****************************************
// internal command channel, four-phase req/ack
// fields must stay stable while req is high
// ****************************************
`default_nettype none

interface rf_cmd_if;
  import capreg_pkg::*;

  logic              req;
  logic              ack;
  rf_op_e            op;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data;
  cap_t              cap;
  // revoke only: also drop the tag
  logic              clrtag;

  // command source side
  modport intake (
    output req, op, addr, data, cap, clrtag,
    input  ack
  );

  // command sink side
  modport regfile (
    input  req, op, addr, data, cap, clrtag,
    output ack
  );

endinterface

`default_nettype wire

// ==== rtl/capreg_pkg.sv ====
// ****************************************
// sizes and capability metadata shared by the register file
// a capability here is only a tag bit and a flat permission field
// ****************************************
`default_nettype none

package capreg_pkg;

  // register file geometry
  localparam int unsigned NUM_REGS = 16;
  localparam int unsigned ADDR_W   = 4;
  localparam int unsigned DATA_W   = 32;

  // width of the permission field carried with each register
  localparam int unsigned PERM_W   = 8;

  // capability metadata, tag in the top bit
  typedef struct packed {
    logic              valid;
    logic [PERM_W-1:0] perms;
  } cap_t;

  // untagged, no permissions
  localparam cap_t NULL_CAP = '{valid: 1'b0, perms: '0};

  // command opcodes
  // 2'b11 is unused and treated as a no-op
  typedef enum logic [1:0] {
    OP_WRITE   = 2'b00,
    OP_RESERVE = 2'b01,
    OP_REVOKE  = 2'b10
  } rf_op_e;

endpackage

`default_nettype wire
